// ==== build.f ====
src/ctrlPkg.sv
src/opcodeDecoder.sv
src/timingSequencer.sv
src/addrStepRom.sv
src/execStepRom.sv
src/stepMerge.sv
src/controlUnit.sv
dv/controlUnit_properties.sv
dv/controlUnitTb.sv

// ==== dv/controlUnitTb.sv ====
`default_nettype none
`timescale 1ns/10ps

module controlUnitTb;

    localparam int NumOpcodes   = 300;
    localparam int TimeoutLimit = NumOpcodes * 20; // Generous bound per opcode.

    logic                             clk;
    logic                             nrst;
    logic                             opValid;
    ctrlPkg::opcodeT                  opData;
    logic                             opReady;
    logic                             ctrlReady;
    logic                             ctrlValid;
    logic                             ctrlMode;
    logic [ctrlPkg::TimeWidth-1:0]    ctrlTime;
    logic [ctrlPkg::InstrWidth-1:0]   ctrlInstr;
    logic [ctrlPkg::AddrSrcWidth-1:0] ctrlAddrSrc;
    logic [ctrlPkg::AluOpWidth-1:0]   ctrlAluOp;
    logic                             ctrlRegWrite;
    logic                             ctrlMemWrite;
    logic                             ctrlLast;

    // Word layout {mode, time, instr, addrSrc, aluOp, regWrite, memWrite, last}.
    logic [18:0] expected[$]; // Words still owed by the DUT.
    logic [18:0] expWord;
    logic [31:0] lfsrState;
    logic        driveOn;     // Random driver active.
    logic        opTaken;     // Opcode moves at the coming edge.
    int          sentCount;
    int          sendLimit;
    int          cycleCount;

    controlUnit i_controlUnit (
        .clk          (clk),
        .nrst         (nrst),
        .opValid      (opValid),
        .opData       (opData),
        .opReady      (opReady),
        .ctrlReady    (ctrlReady),
        .ctrlValid    (ctrlValid),
        .ctrlMode     (ctrlMode),
        .ctrlTime     (ctrlTime),
        .ctrlInstr    (ctrlInstr),
        .ctrlAddrSrc  (ctrlAddrSrc),
        .ctrlAluOp    (ctrlAluOp),
        .ctrlRegWrite (ctrlRegWrite),
        .ctrlMemWrite (ctrlMemWrite),
        .ctrlLast     (ctrlLast)
    );

    bind controlUnit controlUnitProperties i_controlUnitProperties (.*);

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] randBits(input int count);
        logic [7:0] value;
        logic       feedback;
        int         i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback}; // Taps 32, 22, 2, 1.
            value     = {value[6:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [18:0] makeWord(input logic mode, input logic [2:0] timeVal,
        input logic [5:0] instr, input logic [1:0] src, input logic [3:0] alu,
        input logic regWr, input logic memWr, input logic last);
        return {mode, timeVal, instr, src, alu, regWr, memWr, last};
    endfunction

    task automatic expandOpcode(input ctrlPkg::opcodeT op);
        logic [5:0] instr;
        logic       lastStep;
        int         addrSteps;
        int         execSteps;
        int         t;
        instr = op[7:2];
        case (op[1:0])
            2'd1:    addrSteps = 1; // Zero page.
            2'd2:    addrSteps = 2; // Absolute.
            2'd3:    addrSteps = 4; // Indirect.
            default: addrSteps = 0; // Implied mode gives a bubble only.
        endcase
        execSteps = 1 + (instr % 4);
        for (t = 0; t < addrSteps; t++) begin
            lastStep = (t == addrSteps - 1);
            expected.push_back(makeWord(1'b0, t[2:0], instr, t[1:0], 4'd0, 1'b0, 1'b0,
                lastStep));
        end
        for (t = 0; t < execSteps; t++) begin
            lastStep = (t == execSteps - 1); // Results commit here only.
            expected.push_back(makeWord(1'b1, t[2:0], instr, 2'd0,
                lastStep ? instr[3:0] : 4'd0, lastStep && instr[4], lastStep && instr[5],
                lastStep));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
        input logic [31:0] expValue);
        if (actual !== expValue) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expValue);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic failRun(input string reason);
        $display("ERROR: %s", reason);
        $display("** FAIL **");
        $fatal(1, "Run stopped");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, stimulus and monitor
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutLimit) begin
            failRun("timeout, the DUT stopped issuing words");
        end
    end

    always @(posedge clk) begin
        #1;
        if (driveOn) begin
            if (!opValid || opTaken) begin // Held byte stays until taken.
                opValid = (sentCount < sendLimit) && (randBits(2) != 8'd0);
                opData  = randBits(8);
            end
            ctrlReady = (randBits(2) != 8'd0);
        end
    end

    // Inputs have settled by mid-cycle.
    always @(negedge clk) begin
        opTaken = nrst && opValid && opReady;
        if (opTaken) begin
            expandOpcode(opData);
            sentCount = sentCount + 1;
        end
        if (nrst && ctrlValid && ctrlReady) begin
            if (expected.size() == 0) begin
                failRun("control word arrived when none was expected");
            end else begin
                expWord = expected.pop_front();
                checkValue("ctrlMode", ctrlMode, expWord[18]);
                checkValue("ctrlTime", ctrlTime, expWord[17:15]);
                checkValue("ctrlInstr", ctrlInstr, expWord[14:9]);
                checkValue("ctrlAddrSrc", ctrlAddrSrc, expWord[8:7]);
                checkValue("ctrlAluOp", ctrlAluOp, expWord[6:3]);
                checkValue("ctrlRegWrite", ctrlRegWrite, expWord[2]);
                checkValue("ctrlMemWrite", ctrlMemWrite, expWord[1]);
                checkValue("ctrlLast", ctrlLast, expWord[0]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    task automatic applyReset();
        nrst      = 1'b0;
        opValid   = 1'b0;
        ctrlReady = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        checkValue("ctrlValid", ctrlValid, 0);
        checkValue("opReady", opReady, 1);
        expected.delete();
        expandOpcode(8'h00); // Reset state runs like opcode 00.
        nrst = 1'b1;
        @(posedge clk); // First edge out of reset is a bubble.
        @(negedge clk);
        checkValue("ctrlValid", ctrlValid, 0);
        checkValue("opReady", opReady, 1);
    endtask

    // A word is held and the buffer is full, so reset lands on a busy unit.
    task automatic fillPipeline();
        opValid   = 1'b1;
        opData    = randBits(8);
        ctrlReady = 1'b0;
        @(negedge clk);
        while (!(ctrlValid && !opReady)) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Last exec step of the final opcode waits for a byte that never comes.
    task automatic runPhase(input int count);
        sendLimit = sendLimit + count;
        driveOn   = 1'b1;
        while (!(sentCount == sendLimit && expected.size() == 1)) @(posedge clk);
        driveOn = 1'b0;
        #1;
        opValid   = 1'b0;
        ctrlReady = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        checkValue("pending words", expected.size(), 1);
        checkValue("ctrlValid", ctrlValid, 0);
    endtask

    initial begin
        lfsrState  = 32'ha922_45df;
        nrst       = 1'b0;
        opValid    = 1'b0;
        opData     = '0;
        ctrlReady  = 1'b0;
        driveOn    = 1'b0;
        opTaken    = 1'b0;
        sentCount  = 0;
        sendLimit  = 0;
        cycleCount = 0;
        applyReset();
        runPhase(NumOpcodes / 2);
        fillPipeline();
        applyReset(); // Reset in the middle of the run.
        runPhase(NumOpcodes - NumOpcodes / 2);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/controlUnit_properties.sv ====
`default_nettype none
`timescale 1ns/10ps

module controlUnitProperties (
    input wire logic                                clk,
    input wire logic                                nrst,
    input wire logic                                opValid,
    input wire ctrlPkg::opcodeT                     opData,
    input wire logic                                opReady,
    input wire logic                                ctrlReady,
    input wire logic                                ctrlValid,
    input wire logic                                ctrlMode,
    input wire logic [ctrlPkg::TimeWidth-1:0]       ctrlTime,
    input wire logic [ctrlPkg::InstrWidth-1:0]      ctrlInstr,
    input wire logic [ctrlPkg::AddrSrcWidth-1:0]    ctrlAddrSrc,
    input wire logic [ctrlPkg::AluOpWidth-1:0]      ctrlAluOp,
    input wire logic                                ctrlRegWrite,
    input wire logic                                ctrlMemWrite,
    input wire logic                                ctrlLast
);

    logic [18:0] ctrlWord; // All output fields together.

    assign ctrlWord = {ctrlMode, ctrlTime, ctrlInstr, ctrlAddrSrc, ctrlAluOp,
                       ctrlRegWrite, ctrlMemWrite, ctrlLast};

    ctrlHold: assert property (@(posedge clk) disable iff (!nrst)
        ctrlValid && !ctrlReady |=> ctrlValid && $stable(ctrlWord))
        else $error("control word changed while ctrlReady was low");

    opHold: assert property (@(posedge clk) disable iff (!nrst)
        opValid && !opReady |=> opValid && $stable(opData))
        else $error("opcode byte changed before it was accepted");

    timeRange: assert property (@(posedge clk) disable iff (!nrst)
        ctrlTime <= ctrlPkg::T6)
        else $error("ctrlTime is beyond T6");

    // First edge out of reset.
    resetValues: assert property (@(posedge clk) $rose(nrst) |-> !ctrlValid && opReady)
        else $error("ctrlValid or opReady wrong right after reset");

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`default_nettype none
`timescale 1ns/10ps

module controlUnit (
    input  wire logic                                clk,
    input  wire logic                                nrst,
    input  wire logic                                opValid,
    input  wire ctrlPkg::opcodeT                     opData,
    output logic                                     opReady,
    input  wire logic                                ctrlReady,
    output logic                                     ctrlValid,
    output logic                                     ctrlMode,
    output logic [ctrlPkg::TimeWidth-1:0]            ctrlTime,
    output logic [ctrlPkg::InstrWidth-1:0]           ctrlInstr,
    output logic [ctrlPkg::AddrSrcWidth-1:0]         ctrlAddrSrc,
    output logic [ctrlPkg::AluOpWidth-1:0]           ctrlAluOp,
    output logic                                     ctrlRegWrite,
    output logic                                     ctrlMemWrite,
    output logic                                     ctrlLast
);

    //////////////////////////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////////////////////////

    logic                                decValid;
    logic [ctrlPkg::InstrWidth-1:0]      decInstr;
    logic [ctrlPkg::AddrModeWidth-1:0]   decAddrMode;
    logic                                mode;
    logic [ctrlPkg::TimeWidth-1:0]       timeState;
    logic [ctrlPkg::InstrWidth-1:0]      curInstr;
    logic [ctrlPkg::AddrModeWidth-1:0]   curAddrMode;
    logic                                noAddressing;
    logic [ctrlPkg::AddrSrcWidth-1:0]    addrSrc;
    logic                                addrLast;
    logic [ctrlPkg::AluOpWidth-1:0]      aluOp;
    logic                                regWrite;
    logic                                memWrite;
    logic                                execLast;
    logic                                advance;
    logic                                getInstruction;
    logic                                endAddressing;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    opcodeDecoder i_opcodeDecoder (
        .clk            (clk),
        .nrst           (nrst),
        .opValid        (opValid),
        .opData         (opData),
        .opReady        (opReady),
        .getInstruction (getInstruction),
        .decValid       (decValid),
        .decInstr       (decInstr),
        .decAddrMode    (decAddrMode)
    );

    timingSequencer i_timingSequencer (
        .clk            (clk),
        .nrst           (nrst),
        .advance        (advance),
        .noAddressing   (noAddressing),
        .getInstruction (getInstruction),
        .endAddressing  (endAddressing),
        .decInstr       (decInstr),
        .decAddrMode    (decAddrMode),
        .mode           (mode),
        .timeState      (timeState),
        .curInstr       (curInstr),
        .curAddrMode    (curAddrMode)
    );

    addrStepRom i_addrStepRom (
        .curAddrMode  (curAddrMode),
        .timeState    (timeState),
        .noAddressing (noAddressing),
        .addrSrc      (addrSrc),
        .addrLast     (addrLast)
    );

    execStepRom i_execStepRom (
        .curInstr  (curInstr),
        .timeState (timeState),
        .aluOp     (aluOp),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .execLast  (execLast)
    );

    stepMerge i_stepMerge (
        .clk            (clk),
        .nrst           (nrst),
        .mode           (mode),
        .timeState      (timeState),
        .curInstr       (curInstr),
        .noAddressing   (noAddressing),
        .decValid       (decValid),
        .addrSrc        (addrSrc),
        .addrLast       (addrLast),
        .aluOp          (aluOp),
        .regWrite       (regWrite),
        .memWrite       (memWrite),
        .execLast       (execLast),
        .advance        (advance),
        .getInstruction (getInstruction),
        .endAddressing  (endAddressing),
        .ctrlReady      (ctrlReady),
        .ctrlValid      (ctrlValid),
        .ctrlMode       (ctrlMode),
        .ctrlTime       (ctrlTime),
        .ctrlInstr      (ctrlInstr),
        .ctrlAddrSrc    (ctrlAddrSrc),
        .ctrlAluOp      (ctrlAluOp),
        .ctrlRegWrite   (ctrlRegWrite),
        .ctrlMemWrite   (ctrlMemWrite),
        .ctrlLast       (ctrlLast)
    );

endmodule

`default_nettype wire

// ==== src/stepMerge.sv ====
`default_nettype none
`timescale 1ns/10ps

module stepMerge (
    input  wire logic                                clk,
    input  wire logic                                nrst,
    input  wire logic                                mode,
    input  wire logic [ctrlPkg::TimeWidth-1:0]       timeState,
    input  wire logic [ctrlPkg::InstrWidth-1:0]      curInstr,
    input  wire logic                                noAddressing,
    input  wire logic                                decValid,
    input  wire logic [ctrlPkg::AddrSrcWidth-1:0]    addrSrc,
    input  wire logic                                addrLast,
    input  wire logic [ctrlPkg::AluOpWidth-1:0]      aluOp,
    input  wire logic                                regWrite,
    input  wire logic                                memWrite,
    input  wire logic                                execLast,
    output logic                                     advance,
    output logic                                     getInstruction,
    output logic                                     endAddressing,
    input  wire logic                                ctrlReady,
    output logic                                     ctrlValid,
    output logic                                     ctrlMode,
    output logic [ctrlPkg::TimeWidth-1:0]            ctrlTime,
    output logic [ctrlPkg::InstrWidth-1:0]           ctrlInstr,
    output logic [ctrlPkg::AddrSrcWidth-1:0]         ctrlAddrSrc,
    output logic [ctrlPkg::AluOpWidth-1:0]           ctrlAluOp,
    output logic                                     ctrlRegWrite,
    output logic                                     ctrlMemWrite,
    output logic                                     ctrlLast
);

    logic inAddress;   // Addressing table is active.
    logic regFree;     // Output register can take a word.
    logic bubble;      // Mode switch with no word.
    logic lastPending; // Last step waits for the next opcode.
    logic produce;     // A word is loaded this cycle.

    //////////////////////////////////////////////////////////////////////
    // Stepping control
    //////////////////////////////////////////////////////////////////////

    assign inAddress   = (mode == ctrlPkg::ModeAddress);
    assign regFree     = !ctrlValid || ctrlReady;
    assign bubble      = inAddress && noAddressing;
    assign lastPending = !inAddress && execLast && !decValid;

    assign advance = regFree && !lastPending;
    assign produce = advance && !bubble;

    assign endAddressing  = advance && inAddress && addrLast;
    assign getInstruction = advance && !inAddress && execLast;

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctrlValid <= 1'b0;
        end else if (produce) begin
            ctrlValid <= 1'b1;
        end else if (ctrlReady) begin
            ctrlValid <= 1'b0; // Drained with nothing behind it.
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctrlMode     <= ctrlPkg::ModeAddress;
            ctrlTime     <= ctrlPkg::T0;
            ctrlInstr    <= '0;
            ctrlAddrSrc  <= '0;
            ctrlAluOp    <= '0;
            ctrlRegWrite <= 1'b0;
            ctrlMemWrite <= 1'b0;
            ctrlLast     <= 1'b0;
        end else if (produce) begin
            ctrlMode     <= mode;
            ctrlTime     <= timeState;
            ctrlInstr    <= curInstr;
            ctrlAddrSrc  <= inAddress ? addrSrc : '0;
            ctrlAluOp    <= inAddress ? '0 : aluOp; // No ALU during addressing.
            ctrlRegWrite <= !inAddress && regWrite;
            ctrlMemWrite <= !inAddress && memWrite;
            ctrlLast     <= inAddress ? addrLast : execLast;
        end
    end

endmodule

`default_nettype wire

// ==== src/execStepRom.sv ====
`default_nettype none
`timescale 1ns/10ps

module execStepRom (
    input  wire logic [ctrlPkg::InstrWidth-1:0]      curInstr,
    input  wire logic [ctrlPkg::TimeWidth-1:0]       timeState,
    output logic [ctrlPkg::AluOpWidth-1:0]           aluOp,
    output logic                                     regWrite,
    output logic                                     memWrite,
    output logic                                     execLast
);

    logic [ctrlPkg::TimeWidth-1:0] lastTime; // Final step index.

    // Instruction runs 1 + (instr mod 4) steps.
    assign lastTime = ctrlPkg::TimeWidth'(curInstr[1:0]);
    assign execLast = (timeState == lastTime);

    // Results are committed on the last step only.
    assign aluOp    = execLast ? curInstr[ctrlPkg::AluOpWidth-1:0] : '0;
    assign regWrite = execLast && curInstr[4];
    assign memWrite = execLast && curInstr[5];

endmodule

`default_nettype wire

// ==== src/addrStepRom.sv ====
`default_nettype none
`timescale 1ns/10ps

module addrStepRom (
    input  wire logic [ctrlPkg::AddrModeWidth-1:0]   curAddrMode,
    input  wire logic [ctrlPkg::TimeWidth-1:0]       timeState,
    output logic                                     noAddressing,
    output logic [ctrlPkg::AddrSrcWidth-1:0]         addrSrc,
    output logic                                     addrLast
);

    logic [ctrlPkg::TimeWidth-1:0] stepCount; // Addressing steps of the mode.
    logic [ctrlPkg::TimeWidth-1:0] lastTime;

    always_comb begin
        case (curAddrMode)
            ctrlPkg::AmZeroPage: stepCount = 3'd1;
            ctrlPkg::AmAbsolute: stepCount = 3'd2;
            ctrlPkg::AmIndirect: stepCount = 3'd4;
            default:             stepCount = 3'd0; // Implied and unused codes.
        endcase
    end

    assign lastTime     = stepCount - 1'b1;
    assign noAddressing = (stepCount == '0);

    // Each step drives the address bus from a different source.
    assign addrSrc  = timeState[ctrlPkg::AddrSrcWidth-1:0];
    assign addrLast = !noAddressing && (timeState == lastTime);

endmodule

`default_nettype wire

// ==== src/timingSequencer.sv ====
`default_nettype none
`timescale 1ns/10ps

module timingSequencer (
    input  wire logic                                clk,
    input  wire logic                                nrst,
    input  wire logic                                advance,
    input  wire logic                                noAddressing,
    input  wire logic                                getInstruction,
    input  wire logic                                endAddressing,
    input  wire logic [ctrlPkg::InstrWidth-1:0]      decInstr,
    input  wire logic [ctrlPkg::AddrModeWidth-1:0]   decAddrMode,
    output logic                                     mode,
    output logic [ctrlPkg::TimeWidth-1:0]            timeState,
    output logic [ctrlPkg::InstrWidth-1:0]           curInstr,
    output logic [ctrlPkg::AddrModeWidth-1:0]        curAddrMode
);

    logic                              nextMode;
    logic [ctrlPkg::TimeWidth-1:0]     nextTime;

    //////////////////////////////////////////////////////////////////////
    // Mode and time-state next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextMode = mode;
        if (endAddressing) begin
            nextMode = ctrlPkg::ModeInstruction; // Operand ready, start execution.
            nextTime = ctrlPkg::T0;
        end else if (getInstruction) begin
            nextMode = ctrlPkg::ModeAddress; // New opcode starts with addressing.
            nextTime = ctrlPkg::T0;
        end else begin
            case (timeState)
                ctrlPkg::T0: nextTime = ctrlPkg::T1;
                ctrlPkg::T1: nextTime = ctrlPkg::T2;
                ctrlPkg::T2: nextTime = ctrlPkg::T3;
                ctrlPkg::T3: nextTime = ctrlPkg::T4;
                ctrlPkg::T4: nextTime = ctrlPkg::T5;
                ctrlPkg::T5: nextTime = ctrlPkg::T6;
                default:     nextTime = ctrlPkg::T0; // Wrap after T6.
            endcase
        end

        // Modes without operand skip straight to execution.
        if ((mode == ctrlPkg::ModeAddress) && noAddressing) begin
            nextMode = ctrlPkg::ModeInstruction;
            nextTime = ctrlPkg::T0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // State registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mode      <= ctrlPkg::ModeAddress;
            timeState <= ctrlPkg::T0;
        end else if (advance) begin
            mode      <= nextMode;
            timeState <= nextTime;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            curInstr    <= '0;
            curAddrMode <= ctrlPkg::AmImplied;
        end else if (advance && getInstruction) begin
            curInstr    <= decInstr; // Latch the buffered opcode.
            curAddrMode <= decAddrMode;
        end
    end

endmodule

`default_nettype wire

// ==== src/opcodeDecoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module opcodeDecoder (
    input  wire logic                                clk,
    input  wire logic                                nrst,
    input  wire logic                                opValid,
    input  wire ctrlPkg::opcodeT                     opData,
    output logic                                     opReady,
    input  wire logic                                getInstruction,
    output logic                                     decValid,
    output logic [ctrlPkg::InstrWidth-1:0]           decInstr,
    output logic [ctrlPkg::AddrModeWidth-1:0]        decAddrMode
);

    logic            bufValid; // Buffer holds an opcode.
    ctrlPkg::opcodeT bufData;

    // Free slot, or the held opcode leaves this cycle.
    assign opReady = !bufValid || getInstruction;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bufValid <= 1'b0;
        end else if (opValid && opReady) begin
            bufValid <= 1'b1; // Refill, possibly while consumed.
        end else if (getInstruction) begin
            bufValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (opValid && opReady) begin
            bufData <= opData;
        end
    end

    assign decValid = bufValid;
    assign decInstr = bufData[7:2]; // Upper six bits pick the instruction.

    always_comb begin
        case (bufData[1:0])
            2'b00:   decAddrMode = ctrlPkg::AmImplied;
            2'b01:   decAddrMode = ctrlPkg::AmZeroPage;
            2'b10:   decAddrMode = ctrlPkg::AmAbsolute;
            default: decAddrMode = ctrlPkg::AmIndirect;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////

    localparam int InstrWidth    = 6; // Instruction number.
    localparam int AddrModeWidth = 4; // Addressing-mode code.
    localparam int TimeWidth     = 3; // Time state T0..T6.
    localparam int AluOpWidth    = 4; // ALU operation.
    localparam int AddrSrcWidth  = 2; // Address source select.

    //////////////////////////////////////////////////////////////////////
    // Sequencer codes
    //////////////////////////////////////////////////////////////////////

    localparam logic ModeAddress     = 1'b0; // Addressing steps.
    localparam logic ModeInstruction = 1'b1; // Execution steps.

    localparam logic [TimeWidth-1:0] T0 = 3'd0;
    localparam logic [TimeWidth-1:0] T1 = 3'd1;
    localparam logic [TimeWidth-1:0] T2 = 3'd2;
    localparam logic [TimeWidth-1:0] T3 = 3'd3;
    localparam logic [TimeWidth-1:0] T4 = 3'd4;
    localparam logic [TimeWidth-1:0] T5 = 3'd5;
    localparam logic [TimeWidth-1:0] T6 = 3'd6; // Last legal time state.

    //////////////////////////////////////////////////////////////////////
    // Addressing modes
    //////////////////////////////////////////////////////////////////////

    localparam logic [AddrModeWidth-1:0] AmImplied  = 4'd0; // No operand.
    localparam logic [AddrModeWidth-1:0] AmZeroPage = 4'd1; // One address step.
    localparam logic [AddrModeWidth-1:0] AmAbsolute = 4'd2; // Two address steps.
    localparam logic [AddrModeWidth-1:0] AmIndirect = 4'd3; // Four address steps.

    typedef logic [7:0] opcodeT; // Raw opcode byte.

endpackage

`default_nettype wire
